// File: source/cam_geom_pkg.sv
// ********************
// cam geometry package
// sizes of the shift register CAM and the vector types
// for keys, entry indexes, row masks and slice values
// ********************

package cam_geom_pkg;

    // key width in bits
    localparam int data_width = 16;
    // entry index width
    localparam int addr_width = 3;
    // key bits decoded by one shift register
    localparam int slice_width = 4;
    // slices per row, rounded up to cover the key
    localparam int slice_count = (data_width + slice_width - 1) / slice_width;
    // number of entries
    localparam int ram_depth = 2 ** addr_width;
    // one bit per possible slice value
    localparam int srl_len = 2 ** slice_width;

    // stored or compared key
    typedef logic [data_width-1:0] cam_data_t;
    // entry index
    typedef logic [addr_width-1:0] cam_addr_t;
    // one bit per entry, match vectors and shift enables
    typedef logic [ram_depth-1:0] cam_row_t;
    // value of a single key slice
    typedef logic [slice_width-1:0] cam_slice_t;
    // shift-in bit per slice of a row
    typedef logic [slice_count-1:0] cam_slices_t;

endpackage

// File: source/cam_ctrl_pkg.sv
// ********************
// cam control package
// write controller states and serial count
// ********************

package cam_ctrl_pkg;

    // init clears every row, write/delete rebuild one row
    typedef enum logic [1:0] {
        st_init,
        st_idle,
        st_write,
        st_delete
    } cam_wr_state_t;

    // serial count, one step per shift register position
    // runs from all ones down to zero
    typedef logic [cam_geom_pkg::slice_width-1:0] cam_count_t;

endpackage

// File: source/cam_srl.sv
// ********************
// shift register CAM core
// rows of SRL slices used as one-hot value tables
// init/write/delete controller rebuilds a row serially
// compare gives a registered match vector
// ********************

`timescale 1ns/10ps

module cam_srl (
    input  logic                    clk,
    input  logic                    rst,
    input  cam_geom_pkg::cam_addr_t write_addr,
    input  cam_geom_pkg::cam_data_t write_data,
    input  logic                    write_delete,
    input  logic                    write_enable,
    output logic                    write_busy,
    input  cam_geom_pkg::cam_data_t compare_data,
    output cam_geom_pkg::cam_row_t  match_many
);

    // keys zero extended to whole slices
    logic [cam_geom_pkg::slice_count*cam_geom_pkg::slice_width-1:0] compare_pad;
    logic [cam_geom_pkg::slice_count*cam_geom_pkg::slice_width-1:0] write_pad;

    cam_ctrl_pkg::cam_wr_state_t state_q;
    cam_ctrl_pkg::cam_wr_state_t state_next;
    cam_ctrl_pkg::cam_count_t    count_q;
    cam_ctrl_pkg::cam_count_t    count_next;

    // captured write request
    cam_geom_pkg::cam_addr_t wr_addr_q;
    cam_geom_pkg::cam_addr_t wr_addr_next;
    logic [cam_geom_pkg::slice_count*cam_geom_pkg::slice_width-1:0] wr_data_q;
    logic [cam_geom_pkg::slice_count*cam_geom_pkg::slice_width-1:0] wr_data_next;

    // per row shift enable and per slice shift-in bit
    cam_geom_pkg::cam_row_t    shift_en;
    cam_geom_pkg::cam_slices_t shift_data;

    logic busy_q;

    // combined hit of all slices, per row
    wire cam_geom_pkg::cam_row_t match_raw;
    cam_geom_pkg::cam_row_t      match_many_q;

    assign compare_pad = compare_data;
    assign write_pad   = write_data;

    assign write_busy = busy_q;
    assign match_many = match_many_q;

    // storage array, rows by slices
    for (genvar r = 0; r < cam_geom_pkg::ram_depth; r++) begin : row
        wire cam_geom_pkg::cam_slices_t slice_hit;

        for (genvar s = 0; s < cam_geom_pkg::slice_count; s++) begin : slice
            logic [cam_geom_pkg::srl_len-1:0] srl_mem;
            cam_geom_pkg::cam_slice_t         cmp_slice;

            assign cmp_slice =
                compare_pad[s*cam_geom_pkg::slice_width +: cam_geom_pkg::slice_width];

            // bit at the slice value says this value is stored
            assign slice_hit[s] = srl_mem[cmp_slice];

            // serial rebuild, count 15 lands at the top bit
            always_ff @(posedge clk) begin
                if (shift_en[r]) begin
                    srl_mem <= {srl_mem[cam_geom_pkg::srl_len-2:0], shift_data[s]};
                end
            end
        end

        // row being rebuilt never matches
        assign match_raw[r] = ~shift_en[r] & (&slice_hit);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            match_many_q <= '0;
        end else begin
            match_many_q <= match_raw;
        end
    end

    // write controller
    always_comb begin
        state_next   = state_q;
        count_next   = count_q;
        shift_en     = '0;
        shift_data   = '0;
        wr_addr_next = wr_addr_q;
        wr_data_next = wr_data_q;

        case (state_q)
            cam_ctrl_pkg::st_init: begin
                // clear all rows at once
                shift_en = '1;
                if (count_q == '0) begin
                    state_next = cam_ctrl_pkg::st_idle;
                end else begin
                    count_next = count_q - 1'b1;
                end
            end
            cam_ctrl_pkg::st_idle: begin
                // accept only here, busy is low in idle
                if (write_enable) begin
                    wr_addr_next = write_addr;
                    wr_data_next = write_pad;
                    count_next   = '1;
                    if (write_delete) begin
                        state_next = cam_ctrl_pkg::st_delete;
                    end else begin
                        state_next = cam_ctrl_pkg::st_write;
                    end
                end
            end
            cam_ctrl_pkg::st_write: begin
                shift_en = cam_geom_pkg::cam_row_t'(1) << wr_addr_q;
                // one at the position equal to each key slice
                for (int i = 0; i < cam_geom_pkg::slice_count; i++) begin
                    shift_data[i] = (count_q ==
                        wr_data_q[i*cam_geom_pkg::slice_width +: cam_geom_pkg::slice_width]);
                end
                if (count_q == '0) begin
                    state_next = cam_ctrl_pkg::st_idle;
                end else begin
                    count_next = count_q - 1'b1;
                end
            end
            cam_ctrl_pkg::st_delete: begin
                // zeros everywhere, row can no longer hit
                shift_en = cam_geom_pkg::cam_row_t'(1) << wr_addr_q;
                if (count_q == '0) begin
                    state_next = cam_ctrl_pkg::st_idle;
                end else begin
                    count_next = count_q - 1'b1;
                end
            end
            default: begin
                state_next = cam_ctrl_pkg::st_init;
                count_next = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= cam_ctrl_pkg::st_init;
            count_q <= '1;
            busy_q  <= 1'b1;
        end else begin
            state_q <= state_next;
            count_q <= count_next;
            // high from the cycle after acceptance until the last shift
            busy_q  <= (state_next != cam_ctrl_pkg::st_idle);
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q <= wr_addr_next;
        wr_data_q <= wr_data_next;
    end

endmodule

// File: source/priority_encoder.sv
// ********************
// priority encoder
// lowest set bit wins, found by a binary tree
// gives valid, index and the one-hot winner
// ********************

`timescale 1ns/10ps

module priority_encoder #(
    parameter int width = 8
) (
    input  logic [width-1:0]         unencoded,
    output logic                     valid,
    output logic [$clog2(width)-1:0] encoded,
    output logic [width-1:0]         single
);

    // input padded to a power of two, extra bits never set
    logic [2**$clog2(width)-1:0] in_pad;

    always_comb begin
        in_pad = '0;
        in_pad[width-1:0] = unencoded;
    end

    // each level halves the node count and adds one index bit
    for (genvar l = 0; l < $clog2(width); l++) begin : level
        wire [2**($clog2(width)-l-1)-1:0] v;
        wire [l:0] idx [2**($clog2(width)-l-1)];

        for (genvar n = 0; n < 2**($clog2(width)-l-1); n++) begin : node
            if (l == 0) begin : leaf
                // pair of input bits, low one preferred
                assign v[n]   = in_pad[2*n] | in_pad[2*n+1];
                assign idx[n] = ~in_pad[2*n];
            end else begin : inner
                assign v[n] = level[l-1].v[2*n] | level[l-1].v[2*n+1];
                // low half wins whenever it has any bit set
                assign idx[n] = level[l-1].v[2*n] ?
                    {1'b0, level[l-1].idx[2*n]} :
                    {1'b1, level[l-1].idx[2*n+1]};
            end
        end
    end

    // root node covers the whole input
    assign valid   = level[$clog2(width)-1].v[0];
    assign encoded = level[$clog2(width)-1].idx[0];

    // same winner as a one-hot vector
    assign single = valid ? (width'(1) << encoded) : '0;

endmodule

// File: source/cam_lookup_top.sv
// ********************
// cam lookup top
// shift register CAM core followed by
// a lowest-index priority encoder
// ********************

`timescale 1ns/10ps

module cam_lookup_top (
    input  logic                    clk,
    input  logic                    rst,
    input  cam_geom_pkg::cam_addr_t write_addr,
    input  cam_geom_pkg::cam_data_t write_data,
    input  logic                    write_delete,
    input  logic                    write_enable,
    output logic                    write_busy,
    input  cam_geom_pkg::cam_data_t compare_data,
    output cam_geom_pkg::cam_row_t  match_many,
    output cam_geom_pkg::cam_row_t  match_single,
    output cam_geom_pkg::cam_addr_t match_addr,
    output logic                    match
);

    // storage, write controller and registered match vector
    cam_srl cam_i (
        .clk          (clk),
        .rst          (rst),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .write_delete (write_delete),
        .write_enable (write_enable),
        .write_busy   (write_busy),
        .compare_data (compare_data),
        .match_many   (match_many)
    );

    // combinational, same cycle as match_many
    priority_encoder #(
        .width (cam_geom_pkg::ram_depth)
    ) enc_i (
        .unencoded (match_many),
        .valid     (match),
        .encoded   (match_addr),
        .single    (match_single)
    );

endmodule

// File: tests/cam_lookup_checker.sv
// ********************
// cam lookup checker
// concurrent assertions on the encoder outputs
// and on the write busy window, bound to the top
// ********************

`timescale 1ns/10ps

module cam_lookup_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   write_enable,
    input logic                   write_busy,
    input cam_geom_pkg::cam_row_t match_many,
    input cam_geom_pkg::cam_row_t match_single,
    input logic                   match
);

    // hit flag is the OR of the match vector
    match_is_or: assert property (@(posedge clk) disable iff (rst)
        match == (|match_many))
        else $error("match differs from the OR of match_many");

    // winner is one-hot or empty, and always one of the matching rows
    single_in_many: assert property (@(posedge clk) disable iff (rst)
        $onehot0(match_single) && ((match_single & ~match_many) == '0))
        else $error("match_single is not a one-hot subset of match_many");

    // accepted request gives exactly 16 busy cycles
    busy_window: assert property (@(posedge clk) disable iff (rst)
        (write_enable && !write_busy) |=> write_busy [*16] ##1 !write_busy)
        else $error("write_busy window after an accepted request is wrong");

endmodule

bind cam_lookup_top cam_lookup_checker checker_i (
    .clk          (clk),
    .rst          (rst),
    .write_enable (write_enable),
    .write_busy   (write_busy),
    .match_many   (match_many),
    .match_single (match_single),
    .match        (match)
);

// File: tests/cam_lookup_tb.sv
// ********************
// cam lookup testbench
// writes, deletes and searches against a model
// of valid entries and keys
// ********************

`timescale 1ns/10ps

module cam_lookup_tb;

    localparam int max_cycles = 6000;
    localparam int random_searches = 300;
    localparam int depth = cam_geom_pkg::ram_depth;

    logic                    clk;
    logic                    rst;
    cam_geom_pkg::cam_addr_t write_addr;
    cam_geom_pkg::cam_data_t write_data;
    logic                    write_delete;
    logic                    write_enable;
    logic                    write_busy;
    cam_geom_pkg::cam_data_t compare_data;
    cam_geom_pkg::cam_row_t  match_many;
    cam_geom_pkg::cam_row_t  match_single;
    cam_geom_pkg::cam_addr_t match_addr;
    logic                    match;

    integer seed = 81;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;

    // model of the table, updated on accepted requests
    logic                    model_valid [depth];
    cam_geom_pkg::cam_data_t model_key [depth];
    // expectation for the result that shows up one cycle later
    logic                    exp_check;
    cam_geom_pkg::cam_row_t  exp_many;
    // keys the stimulus has written, for picking hits
    cam_geom_pkg::cam_data_t stored_keys [depth];
    cam_geom_pkg::cam_data_t base_keys [depth];

    cam_lookup_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .write_delete (write_delete),
        .write_enable (write_enable),
        .write_busy   (write_busy),
        .compare_data (compare_data),
        .match_many   (match_many),
        .match_single (match_single),
        .match_addr   (match_addr),
        .match        (match)
    );

    always #10 clk = ~clk;

    // rows of valid entries holding this key
    function automatic cam_geom_pkg::cam_row_t expected_match(input cam_geom_pkg::cam_data_t key);
        cam_geom_pkg::cam_row_t row;
        row = '0;
        for (int i = 0; i < depth; i++) begin
            row[i] = model_valid[i] && (model_key[i] == key);
        end
        return row;
    endfunction

    function automatic cam_geom_pkg::cam_addr_t lowest_index(input cam_geom_pkg::cam_row_t row);
        cam_geom_pkg::cam_addr_t idx;
        idx = '0;
        // scan downwards so the lowest set bit is kept last
        for (int i = depth - 1; i >= 0; i--) begin
            if (row[i]) begin
                idx = cam_geom_pkg::cam_addr_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic cam_geom_pkg::cam_row_t lowest_bit(input cam_geom_pkg::cam_row_t row);
        cam_geom_pkg::cam_row_t one;
        one = '0;
        if (row != '0) begin
            one[lowest_index(row)] = 1'b1;
        end
        return one;
    endfunction

    // compare last cycle's search, then capture this one and any accepted write
    always @(posedge clk) begin
        if (rst) begin
            exp_check = 1'b0;
            for (int i = 0; i < depth; i++) begin
                model_valid[i] = 1'b0;
            end
        end else begin
            if (exp_check) begin
                check_count++;
                if (match_many !== exp_many) begin
                    $display("CHECK FAILED match_many: expected %h, got %h", exp_many, match_many);
                    error_count++;
                end
                if (match !== (|exp_many)) begin
                    $display("CHECK FAILED match: expected %h, got %h", |exp_many, match);
                    error_count++;
                end
                if (match_single !== lowest_bit(exp_many)) begin
                    $display("CHECK FAILED match_single: expected %h, got %h",
                        lowest_bit(exp_many), match_single);
                    error_count++;
                end
                // address only means something on a hit
                if ((exp_many != '0) && (match_addr !== lowest_index(exp_many))) begin
                    $display("CHECK FAILED match_addr: expected %h, got %h",
                        lowest_index(exp_many), match_addr);
                    error_count++;
                end
            end
            // a row being rebuilt is masked, so only idle cycles are compared
            exp_check = !write_busy;
            exp_many = expected_match(compare_data);
            if (write_enable && !write_busy) begin
                model_valid[write_addr] = !write_delete;
                model_key[write_addr] = write_data;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("ERROR: timeout, the run did not end within %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic wait_idle();
        @(posedge clk);
        while (write_busy) begin
            @(posedge clk);
        end
    endtask

    // one-cycle strobe once the core is idle
    task automatic request(input cam_geom_pkg::cam_addr_t addr, input cam_geom_pkg::cam_data_t data,
                           input logic del);
        wait_idle();
        write_addr <= addr;
        write_data <= data;
        write_delete <= del;
        write_enable <= 1'b1;
        if (!del) begin
            stored_keys[addr] = data;
        end
        @(posedge clk);
        write_enable <= 1'b0;
        write_delete <= 1'b0;
    endtask

    task automatic search(input cam_geom_pkg::cam_data_t key);
        @(posedge clk);
        compare_data <= key;
    endtask

    initial begin
        int                      busy_cycles;
        cam_geom_pkg::cam_data_t key;
        clk = 1'b0;
        rst = 1'b1;
        write_addr = '0;
        write_data = '0;
        write_delete = 1'b0;
        write_enable = 1'b0;
        compare_data = '0;
        base_keys = '{16'h3a5c, 16'hc0de, 16'h0001, 16'hffff,
                      16'h1234, 16'h8000, 16'h5a5a, 16'h0f0f};
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // init clears the rows, busy meanwhile
        busy_cycles = 0;
        @(posedge clk);
        while (write_busy) begin
            busy_cycles++;
            @(posedge clk);
        end
        if (busy_cycles != 16) begin
            $display("CHECK FAILED write_busy cycles after reset: expected %h, got %h",
                16, busy_cycles);
            error_count++;
        end
        search(16'h0000);
        repeat (20) search(cam_geom_pkg::cam_data_t'($random(seed)));

        // distinct key per entry
        for (int i = 0; i < depth; i++) begin
            request(cam_geom_pkg::cam_addr_t'(i), base_keys[i], 1'b0);
        end
        wait_idle();
        for (int i = 0; i < depth; i++) begin
            search(base_keys[i]);
        end
        search(16'h3a5d);
        search(16'h0000);
        search(16'hfffe);

        // duplicates, lowest entry wins
        request(3'd2, 16'hbeef, 1'b0);
        request(3'd5, 16'hbeef, 1'b0);
        request(3'd6, 16'hbeef, 1'b0);
        wait_idle();
        search(16'hbeef);

        // delete falls through to the next duplicate
        request(3'd2, 16'h0000, 1'b1);
        wait_idle();
        search(16'hbeef);
        request(3'd5, 16'h0000, 1'b1);
        request(3'd6, 16'h0000, 1'b1);
        wait_idle();
        search(16'hbeef);
        // overwrite replaces the old key
        request(3'd0, 16'h6c6c, 1'b0);
        wait_idle();
        search(16'h3a5c);
        search(16'h6c6c);

        // strobes during busy must be dropped
        request(3'd3, 16'h7777, 1'b0);
        repeat (3) begin
            @(posedge clk);
            write_addr <= 3'd4;
            write_data <= 16'h9999;
            write_enable <= 1'b1;
        end
        @(posedge clk);
        write_enable <= 1'b0;
        wait_idle();
        search(16'h7777);
        search(16'h9999);
        search(16'h1234);
        search(16'hffff);

        // random table, some neighbours share a key
        for (int i = 0; i < depth; i++) begin
            key = cam_geom_pkg::cam_data_t'($random(seed));
            if ((i > 0) && (($random(seed) & 3) == 0)) begin
                key = stored_keys[i-1];
            end
            request(cam_geom_pkg::cam_addr_t'(i), key, 1'b0);
        end
        wait_idle();
        for (int n = 0; n < random_searches; n++) begin
            if (($random(seed) & 1) != 0) begin
                search(stored_keys[cam_geom_pkg::cam_addr_t'($random(seed))]);
            end else begin
                search(cam_geom_pkg::cam_data_t'($random(seed)));
            end
        end
        // let the last search come out
        repeat (3) @(posedge clk);

        if (check_count < random_searches) begin
            $display("ERROR: only %0d comparisons ran, fewer than expected", check_count);
            error_count++;
        end
        $display("comparisons %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: cam_lookup.f
source/cam_geom_pkg.sv
source/cam_ctrl_pkg.sv
source/cam_srl.sv
source/priority_encoder.sv
source/cam_lookup_top.sv
tests/cam_lookup_checker.sv
tests/cam_lookup_tb.sv
